// ==== anneal.f ====
source/anneal_pkg.sv
source/energy_fifo.sv
source/energy_fifo_maintainer.sv
source/energy_evaluator.sv
source/spin_proposer.sv
source/wb_anneal_regs.sv
source/anneal_top.sv
test/anneal_sva.sv
test/anneal_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the annealing engine testbench with Verilator, run it, search the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert -Wno-fatal --top-module anneal_tb \
    -f anneal.f -o anneal_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/anneal_sim +verilator+error+limit+100 > sim.log 2>&1
cat sim.log
grep -q "^sim passed$" sim.log && exit 0 || exit 1

// ==== test/anneal_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module anneal_tb;
    import anneal_pkg::*;

    // Bus ack limit in cycles
    localparam int ACK_LIMIT  = 16;
    // Done poll limit in CTRL reads
    localparam int POLL_LIMIT = 3000;

    logic                    clk;
    logic                    rst;
    logic                    wb_cyc;
    logic                    wb_stb;
    logic                    wb_we;
    logic [WB_ADDR_BITS-1:0] wb_adr;
    wb_data_t                wb_dat_w;
    wb_data_t                wb_dat_r;
    logic                    wb_ack;

    int     errors;
    int     timeouts;
    int     sva_fails;
    integer seed;
    // Model copy of the weights
    int     h_w [NUM_SPINS];
    int     j_w;

    anneal_top u_dut (
        .clk_i    (clk),
        .rst_i    (rst),
        .wb_cyc_i (wb_cyc),
        .wb_stb_i (wb_stb),
        .wb_we_i  (wb_we),
        .wb_adr_i (wb_adr),
        .wb_dat_i (wb_dat_w),
        .wb_dat_o (wb_dat_r),
        .wb_ack_o (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    task automatic expect_word(input string what, input wb_data_t got, input wb_data_t exp);
        if (got !== exp) begin
            $display("ERR %0t: %s got %h expected %h", $time, what, got, exp);
            errors++;
        end
    endtask

    // One classic cycle with ack sampled 2 ns after the edge
    task automatic bus_access(input logic we, input logic [WB_ADDR_BITS-1:0] adr,
                              input wb_data_t wdat, output wb_data_t rdat);
        int wait_cnt;
        wait_cnt = 0;
        @(posedge clk);
        #2;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(posedge clk);
        #2;
        while (!wb_ack && wait_cnt < ACK_LIMIT) begin
            @(posedge clk);
            #2;
            wait_cnt++;
        end
        rdat   = wb_dat_r;
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        if (!wb_ack) begin
            $display("timeout: no Wishbone ack for the access at address %0d", adr);
            timeouts++;
        end else begin
            // Ack is due on the first edge after the request
            if (wait_cnt != 0) begin
                $display("ERR %0t: ack %0d cycles late at address %0d", $time, wait_cnt, adr);
                errors++;
            end
            // Ack must be a single-cycle pulse
            @(posedge clk);
            #2;
            if (wb_ack) begin
                $display("ERR %0t: ack longer than one cycle at address %0d", $time, adr);
                errors++;
            end
        end
    endtask

    task automatic write_reg(input logic [WB_ADDR_BITS-1:0] adr, input wb_data_t dat);
        wb_data_t unused;
        bus_access(1'b1, adr, dat, unused);
    endtask

    task automatic read_reg(input logic [WB_ADDR_BITS-1:0] adr, output wb_data_t dat);
        bus_access(1'b0, adr, '0, dat);
    endtask

    task automatic write_readback(input string what, input logic [WB_ADDR_BITS-1:0] adr,
                                  input wb_data_t value, input wb_data_t mask);
        wb_data_t rd;
        write_reg(adr, value);
        read_reg(adr, rd);
        expect_word(what, rd, value & mask);
    endtask

    // Ising energy where spin bit 1 is +1 and 0 is -1
    function automatic int ising_energy(input logic [NUM_SPINS-1:0] s);
        int e;
        int sk;
        int sn;
        int k;
        e = 0;
        for (k = 0; k < NUM_SPINS; k++) begin
            sk = s[k] ? 1 : -1;
            sn = s[(k + 1) % NUM_SPINS] ? 1 : -1;
            e  = e - h_w[k] * sk - j_w * sk * sn;
        end
        return e;
    endfunction

    // Replay of LFSR, single flips and strict-improvement acceptance
    task automatic model_run(input logic [15:0] lfsr_seed, input logic [15:0] init,
                             input int iters, output logic [15:0] best,
                             output int best_e, output int accepts);
        logic [15:0] lfsr;
        logic [15:0] cand;
        int          e;
        int          n;
        lfsr    = lfsr_seed;
        best    = init;
        best_e  = int'(ENERGY_MAX);
        accepts = 0;
        for (n = 0; n < iters; n++) begin
            // Taps 16 14 13 11
            lfsr = {lfsr[14:0], lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]};
            cand = best ^ (16'h1 << lfsr[3:0]);
            e    = ising_energy(cand);
            if (e < best_e) begin
                best    = cand;
                best_e  = e;
                accepts = accepts + 1;
            end
        end
    endtask

    // Nibble k of H_LO is h_k and H_HI holds spins 8 to 15
    task automatic load_weights();
        wb_data_t lo;
        wb_data_t hi;
        int       k;
        for (k = 0; k < 8; k++) begin
            lo[4*k +: 4] = 4'(h_w[k]);
            hi[4*k +: 4] = 4'(h_w[k + 8]);
        end
        write_reg(ADDR_H_LO, lo);
        write_reg(ADDR_H_HI, hi);
        write_reg(ADDR_J, wb_data_t'(4'(j_w)));
    endtask

    // Start a run, poll for done, then compare against the model
    task automatic anneal_and_compare(input string what, input logic [15:0] lfsr_seed,
                                      input logic [15:0] init, input int iters);
        logic [15:0] exp_spin;
        int          exp_e;
        int          exp_acc;
        wb_data_t    rd;
        int          polls;
        polls = 0;
        write_reg(ADDR_SEED, wb_data_t'(lfsr_seed));
        write_reg(ADDR_INIT_SPIN, wb_data_t'(init));
        write_reg(ADDR_CTRL, wb_data_t'((iters << 8) | 1));
        read_reg(ADDR_CTRL, rd);
        while (!rd[1] && polls < POLL_LIMIT && timeouts == 0) begin
            read_reg(ADDR_CTRL, rd);
            polls++;
        end
        if (!rd[1]) begin
            $display("timeout: the %s run never reported done", what);
            timeouts++;
        end else begin
            if (rd[0]) begin
                $display("ERR %0t: %s busy still set with done", $time, what);
                errors++;
            end
            model_run(lfsr_seed, init, iters, exp_spin, exp_e, exp_acc);
            read_reg(ADDR_BEST_SPIN, rd);
            expect_word({what, " BEST_SPIN"}, rd, wb_data_t'(exp_spin));
            read_reg(ADDR_BEST_ENERGY, rd);
            expect_word({what, " BEST_ENERGY"}, rd, wb_data_t'(exp_e));
            read_reg(ADDR_ACCEPT_COUNT, rd);
            expect_word({what, " ACCEPT_COUNT"}, rd, wb_data_t'(exp_acc));
        end
    endtask

    task automatic test_register_access();
        wb_data_t rd;
        read_reg(ADDR_CTRL, rd);
        expect_word("CTRL after reset", rd, '0);
        write_readback("SEED", ADDR_SEED, $random(seed), 32'h0000_ffff);
        write_readback("H_LO", ADDR_H_LO, $random(seed), 32'hffff_ffff);
        write_readback("H_HI", ADDR_H_HI, $random(seed), 32'hffff_ffff);
        write_readback("J", ADDR_J, $random(seed), 32'h0000_000f);
        write_readback("INIT_SPIN", ADDR_INIT_SPIN, $random(seed), 32'h0000_ffff);
    endtask

    // Positive fields alone drive every spin to +1
    task automatic test_positive_field();
        wb_data_t rd;
        int       sum;
        int       k;
        sum = 0;
        for (k = 0; k < NUM_SPINS; k++) begin
            h_w[k] = 1 + ({$random(seed)} % 7);
            sum    = sum + h_w[k];
        end
        j_w = 0;
        load_weights();
        anneal_and_compare("positive field", 16'hace1, 16'h0000, 255);
        read_reg(ADDR_BEST_SPIN, rd);
        expect_word("positive field ground state", rd, 32'h0000_ffff);
        read_reg(ADDR_BEST_ENERGY, rd);
        expect_word("positive field ground energy", rd, wb_data_t'(-sum));
    endtask

    task automatic test_random_weights();
        int k;
        for (k = 0; k < NUM_SPINS; k++) begin
            h_w[k] = $random(seed) % 8;
        end
        j_w = $random(seed) % 8;
        load_weights();
        anneal_and_compare("random weights", 16'($random(seed)) | 16'h1,
                           16'($random(seed)), 90);
    endtask

    // Flat landscape where the first candidate wins and every later tie loses
    task automatic test_tie_rejection();
        wb_data_t rd;
        int       k;
        for (k = 0; k < NUM_SPINS; k++) begin
            h_w[k] = 0;
        end
        j_w = 0;
        load_weights();
        anneal_and_compare("tie", 16'h5a5b, 16'h1234, 20);
        read_reg(ADDR_ACCEPT_COUNT, rd);
        expect_word("tie accept count", rd, 32'd1);
    endtask

    // Second run starts worse than the first best, so only a flushed head accepts
    task automatic test_restart();
        int k;
        for (k = 0; k < NUM_SPINS; k++) begin
            h_w[k] = 1 + ({$random(seed)} % 7);
        end
        j_w = 0;
        load_weights();
        anneal_and_compare("first run", 16'h3c71, 16'h0000, 120);
        anneal_and_compare("restart", 16'h9e02, 16'h0000, 5);
    endtask

    initial begin
        errors   = 0;
        timeouts = 0;
        seed     = 32'hf972;
        rst      = 1'b1;
        wb_cyc   = 1'b0;
        wb_stb   = 1'b0;
        wb_we    = 1'b0;
        wb_adr   = '0;
        wb_dat_w = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;
        if (wb_ack !== 1'b0) begin
            $display("ERR %0t: ack high after reset", $time);
            errors++;
        end
        test_register_access();
        if (timeouts == 0) begin
            test_positive_field();
        end
        if (timeouts == 0) begin
            test_random_weights();
        end
        if (timeouts == 0) begin
            test_tie_rejection();
        end
        if (timeouts == 0) begin
            test_restart();
        end
        sva_fails = u_dut.u_maintainer.u_sva.fail_count;
        $display("check errors %0d, assertion failures %0d, timeouts %0d",
                 errors, sva_fails, timeouts);
        if (errors == 0 && sva_fails == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== test/anneal_sva.sv ====
`timescale 1ns/1ps
`default_nettype none

module anneal_sva (
    input logic                             clk_i,
    input logic                             rst_i,
    input logic                             flush_i,
    input logic                             spin_full_i,
    input logic                             spin_valid_i,
    input logic                             spin_push_none_i,
    input logic [anneal_pkg::USAGE_BITS-1:0] usage_i
);
    import anneal_pkg::*;

    // Running tally of assertion failures
    int fail_count = 0;

    // Pop and push pair up, so one entry stays live between flushes
    usage_one: assert property (@(posedge clk_i) disable iff (rst_i)
        !flush_i |-> usage_i == USAGE_BITS'(1))
        else begin
            fail_count++;
            $error("FIFO usage is not one outside a flush");
        end

    // Result valid only with a spin in the slot
    valid_held: assert property (@(posedge clk_i) disable iff (rst_i)
        spin_valid_i |-> spin_full_i)
        else begin
            fail_count++;
            $error("spin valid raised without a held spin");
        end

    // Flag travels with a valid result
    none_with_valid: assert property (@(posedge clk_i) disable iff (rst_i)
        spin_push_none_i |-> spin_valid_i)
        else begin
            fail_count++;
            $error("push-none raised while spin valid is low");
        end

endmodule

bind energy_fifo_maintainer anneal_sva u_sva (
    .clk_i            (clk_i),
    .rst_i            (rst_i),
    .flush_i          (flush_i),
    .spin_full_i      (spin_full_q),
    .spin_valid_i     (spin_valid_o),
    .spin_push_none_i (spin_push_none_o),
    .usage_i          (debug_fifo_usage_o)
);

`default_nettype wire

// ==== source/anneal_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module anneal_top (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [anneal_pkg::WB_ADDR_BITS-1:0] wb_adr_i,
    input  anneal_pkg::wb_data_t               wb_dat_i,
    output anneal_pkg::wb_data_t               wb_dat_o,
    output logic                               wb_ack_o
);
    import anneal_pkg::*;

    // Run control
    anneal_cfg_t cfg;
    logic        start;
    logic        flush;
    logic        busy;
    logic        prop_done;
    // Candidate path
    spin_t       best_spin;
    spin_t       cand;
    logic        cand_valid;
    logic        spin_ready;
    logic        eval_ready;
    // Energy and result path
    energy_t     cand_energy;
    logic        energy_valid;
    logic        energy_ready;
    logic        res_valid;
    logic        res_push_none;
    spin_t       res_spin;
    energy_t     res_energy;

    wb_anneal_regs u_regs (
        .clk_i, .rst_i, .wb_cyc_i, .wb_stb_i, .wb_we_i, .wb_adr_i, .wb_dat_i,
        .wb_dat_o, .wb_ack_o,
        .prop_done_i (prop_done),      .res_valid_i (res_valid),
        .res_push_none_i (res_push_none), .res_spin_i (res_spin),
        .res_energy_i (res_energy),    .cfg_o (cfg),
        .start_o (start),              .flush_o (flush),
        .busy_o (busy),                .best_spin_o (best_spin)
    );

    spin_proposer u_proposer (
        .clk_i, .rst_i, .start_i (start), .cfg_i (cfg), .best_spin_i (best_spin),
        .spin_ready_i (spin_ready), .eval_ready_i (eval_ready),
        .cand_valid_o (cand_valid), .cand_o (cand), .done_o (prop_done)
    );

    energy_evaluator u_evaluator (
        .clk_i, .rst_i, .cfg_i (cfg), .cand_valid_i (cand_valid), .cand_i (cand),
        .cand_ready_o (eval_ready), .energy_valid_o (energy_valid),
        .energy_o (cand_energy), .energy_ready_i (energy_ready)
    );

    // Result ready tracks busy, as does the energy enable
    energy_fifo_maintainer u_maintainer (
        .clk_i, .rst_i, .flush_i (flush), .en_i (busy),
        .spin_valid_i (cand_valid), .spin_i (cand), .spin_ready_o (spin_ready),
        .energy_valid_i (energy_valid), .energy_i (cand_energy),
        .energy_ready_o (energy_ready), .spin_valid_o (res_valid), .spin_o (res_spin),
        .spin_push_none_o (res_push_none), .energy_o (res_energy),
        .spin_ready_i (busy), .debug_fifo_usage_o ()
    );

endmodule

`default_nettype wire

// ==== source/wb_anneal_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_anneal_regs (
    input  logic                               clk_i,
    input  logic                               rst_i,
    input  logic                               wb_cyc_i,
    input  logic                               wb_stb_i,
    input  logic                               wb_we_i,
    input  logic [anneal_pkg::WB_ADDR_BITS-1:0] wb_adr_i,
    input  anneal_pkg::wb_data_t               wb_dat_i,
    output anneal_pkg::wb_data_t               wb_dat_o,
    output logic                               wb_ack_o,
    input  logic                               prop_done_i,
    input  logic                               res_valid_i,
    input  logic                               res_push_none_i,
    input  anneal_pkg::spin_t                  res_spin_i,
    input  anneal_pkg::energy_t                res_energy_i,
    output anneal_pkg::anneal_cfg_t            cfg_o,
    output logic                               start_o,
    output logic                               flush_o,
    output logic                               busy_o,
    output anneal_pkg::spin_t                  best_spin_o
);
    import anneal_pkg::*;

    anneal_cfg_t cfg_q;
    spin_t       init_spin_q;
    spin_t       best_spin_q;
    energy_t     best_energy_q;
    iter_t       accept_q;
    logic        start_q;
    logic        busy_q;
    logic        done_q;
    logic        ack_q;
    logic        wb_access;
    logic        wb_write;

    // Ack one cycle after the request, single-cycle pulse
    assign wb_access = wb_cyc_i & wb_stb_i & ~ack_q;
    assign wb_write  = wb_access & wb_we_i;
    assign wb_ack_o  = ack_q;

    assign cfg_o       = cfg_q;
    assign start_o     = start_q;
    // Flush rides on the start pulse
    assign flush_o     = start_q;
    assign busy_o      = busy_q;
    assign best_spin_o = best_spin_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            ack_q       <= 1'b0;
            start_q     <= 1'b0;
            cfg_q       <= '0;
            init_spin_q <= '0;
        end else begin
            ack_q   <= wb_access;
            start_q <= wb_write && (wb_adr_i == ADDR_CTRL) && wb_dat_i[0];
            if (wb_write) begin
                case (wb_adr_i)
                    ADDR_CTRL:      cfg_q.iterations <= wb_dat_i[15:8];
                    ADDR_SEED:      cfg_q.seed <= wb_dat_i[LFSR_BITS-1:0];
                    ADDR_H_LO:      cfg_q.h[7:0] <= wb_dat_i;
                    ADDR_H_HI:      cfg_q.h[15:8] <= wb_dat_i;
                    ADDR_J:         cfg_q.j <= wb_dat_i[WEIGHT_BITS-1:0];
                    ADDR_INIT_SPIN: init_spin_q <= wb_dat_i[NUM_SPINS-1:0];
                    default:        ;
                endcase
            end
        end
    end

    // Run control and best-state tracking
    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            busy_q        <= 1'b0;
            done_q        <= 1'b0;
            accept_q      <= '0;
            best_spin_q   <= '0;
            best_energy_q <= ENERGY_MAX;
        end else if (start_q) begin
            busy_q        <= 1'b1;
            done_q        <= 1'b0;
            accept_q      <= '0;
            best_spin_q   <= init_spin_q;
            best_energy_q <= ENERGY_MAX;
        end else if (busy_q) begin
            // Only strict improvements land here
            if (res_valid_i && !res_push_none_i) begin
                best_spin_q   <= res_spin_i;
                best_energy_q <= res_energy_i;
                accept_q      <= accept_q + 1'b1;
            end
            if (prop_done_i && !res_valid_i) begin
                busy_q <= 1'b0;
                done_q <= 1'b1;
            end
        end
    end

    always_comb begin
        wb_dat_o = '0;
        case (wb_adr_i)
            ADDR_CTRL:         wb_dat_o = {30'd0, done_q, busy_q};
            ADDR_SEED:         wb_dat_o = wb_data_t'(cfg_q.seed);
            ADDR_H_LO:         wb_dat_o = cfg_q.h[7:0];
            ADDR_H_HI:         wb_dat_o = cfg_q.h[15:8];
            ADDR_J:            wb_dat_o = wb_data_t'($unsigned(cfg_q.j));
            ADDR_INIT_SPIN:    wb_dat_o = wb_data_t'(init_spin_q);
            ADDR_BEST_SPIN:    wb_dat_o = wb_data_t'(best_spin_q);
            // Sign-extended for the host
            ADDR_BEST_ENERGY:  wb_dat_o = {{(WB_DATA_BITS-ENERGY_BITS){best_energy_q[ENERGY_BITS-1]}},
                                           best_energy_q};
            ADDR_ACCEPT_COUNT: wb_dat_o = wb_data_t'(accept_q);
            default:           wb_dat_o = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== source/spin_proposer.sv ====
`timescale 1ns/1ps
`default_nettype none

module spin_proposer (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  logic                    start_i,
    input  anneal_pkg::anneal_cfg_t cfg_i,
    input  anneal_pkg::spin_t       best_spin_i,
    input  logic                    spin_ready_i,
    input  logic                    eval_ready_i,
    output logic                    cand_valid_o,
    output anneal_pkg::spin_t       cand_o,
    output logic                    done_o
);
    import anneal_pkg::*;

    lfsr_t lfsr_q;
    iter_t iter_q;
    logic  running_q;
    logic  cand_valid_q;
    logic  both_ready;
    logic  budget_left;
    logic  issue;
    logic  feedback;

    // Taps 16 14 13 11
    assign feedback = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];

    assign both_ready  = spin_ready_i & eval_ready_i;
    assign budget_left = (iter_q != cfg_i.iterations);
    // Next candidate only once both paths are free again
    assign issue       = running_q & ~cand_valid_q & both_ready & budget_left;
    assign done_o      = running_q & ~cand_valid_q & both_ready & ~budget_left;

    // Flip index comes from the already shifted LFSR
    assign cand_valid_o = cand_valid_q;
    assign cand_o       = best_spin_i ^ (spin_t'(1) << lfsr_q[3:0]);

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            lfsr_q       <= '0;
            iter_q       <= '0;
            running_q    <= 1'b0;
            cand_valid_q <= 1'b0;
        end else if (start_i) begin
            lfsr_q       <= cfg_i.seed;
            iter_q       <= '0;
            running_q    <= 1'b1;
            cand_valid_q <= 1'b0;
        end else begin
            if (issue) begin
                lfsr_q       <= {lfsr_q[14:0], feedback};
                iter_q       <= iter_q + 1'b1;
                cand_valid_q <= 1'b1;
            end else if (cand_valid_q && both_ready) begin
                cand_valid_q <= 1'b0;
            end
            if (done_o) begin
                running_q <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/energy_evaluator.sv ====
`timescale 1ns/1ps
`default_nettype none

module energy_evaluator (
    input  logic                    clk_i,
    input  logic                    rst_i,
    input  anneal_pkg::anneal_cfg_t cfg_i,
    input  logic                    cand_valid_i,
    input  anneal_pkg::spin_t       cand_i,
    output logic                    cand_ready_o,
    output logic                    energy_valid_o,
    output anneal_pkg::energy_t     energy_o,
    input  logic                    energy_ready_i
);
    import anneal_pkg::*;

    spin_t      cand_q;
    energy_t    acc_q;
    logic [3:0] idx_q;
    logic       run_q;
    logic       valid_q;
    logic       cand_hs;

    // Contribution of site k, field term plus bond to site k+1
    function automatic energy_t site_term(input spin_t s, input logic [3:0] k,
                                          input anneal_cfg_t cfg);
        energy_t h_ext;
        energy_t j_ext;
        energy_t field;
        energy_t bond;
        h_ext = energy_t'(cfg.h[k]);
        j_ext = energy_t'(cfg.j);
        // -h*s
        field = s[k] ? -h_ext : h_ext;
        // -j*s_k*s_k+1, index wraps around the ring
        bond  = (s[k] == s[k + 4'd1]) ? -j_ext : j_ext;
        return field + bond;
    endfunction

    assign cand_ready_o   = ~run_q & ~valid_q;
    assign cand_hs        = cand_valid_i & cand_ready_o;
    assign energy_valid_o = valid_q;
    assign energy_o       = acc_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            idx_q   <= '0;
            run_q   <= 1'b0;
            valid_q <= 1'b0;
        end else if (cand_hs) begin
            // Site 0 folded into the capture cycle
            idx_q <= 4'd1;
            run_q <= 1'b1;
        end else if (run_q) begin
            idx_q <= idx_q + 4'd1;
            if (idx_q == 4'(NUM_SPINS - 1)) begin
                run_q   <= 1'b0;
                valid_q <= 1'b1;
            end
        end else if (valid_q && energy_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (cand_hs) begin
            cand_q <= cand_i;
            acc_q  <= site_term(cand_i, 4'd0, cfg_i);
        end else if (run_q) begin
            acc_q <= acc_q + site_term(cand_q, idx_q, cfg_i);
        end
    end

endmodule

`default_nettype wire

// ==== source/energy_fifo_maintainer.sv ====
`timescale 1ns/1ps
`default_nettype none

module energy_fifo_maintainer (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             flush_i,
    input  logic                             en_i,
    input  logic                             spin_valid_i,
    input  anneal_pkg::spin_t                spin_i,
    output logic                             spin_ready_o,
    input  logic                             energy_valid_i,
    input  anneal_pkg::energy_t              energy_i,
    output logic                             energy_ready_o,
    output logic                             spin_valid_o,
    output anneal_pkg::spin_t                spin_o,
    output logic                             spin_push_none_o,
    output anneal_pkg::energy_t              energy_o,
    input  logic                             spin_ready_i,
    output logic [anneal_pkg::USAGE_BITS-1:0] debug_fifo_usage_o
);
    import anneal_pkg::*;

    logic    fifo_full;
    logic    fifo_empty;
    energy_t fifo_head;
    logic    spin_in_hs;
    logic    spin_out_hs;
    logic    energy_hs;
    logic    no_gain;
    spin_t   spin_q;
    logic    spin_full_q;
    logic    pend_q;
    logic    pend_none_q;
    energy_t pend_energy_q;

    // Best energy so far sits at the FIFO head
    energy_fifo u_energy_fifo (
        .clk_i       (clk_i),
        .rst_i       (rst_i),
        .flush_i     (flush_i),
        .push_i      (energy_hs),
        .pop_i       (energy_hs),
        .push_none_i (no_gain),
        .data_i      (energy_i),
        .data_o      (fifo_head),
        .full_o      (fifo_full),
        .empty_o     (fifo_empty),
        .usage_o     (debug_fifo_usage_o)
    );

    // One spin slot
    assign spin_ready_o = ~spin_full_q;
    assign spin_in_hs   = spin_valid_i & spin_ready_o;

    // Energy only taken against a held spin and a live head
    assign energy_ready_o = en_i & spin_full_q & ~pend_q & ~fifo_full & ~fifo_empty;
    assign energy_hs      = energy_valid_i & energy_ready_o;
    // Ties count as no improvement
    assign no_gain        = (energy_i >= fifo_head);

    // Result goes out in the energy cycle, or later from the pending copy
    assign spin_valid_o     = energy_hs | pend_q;
    assign spin_push_none_o = (energy_hs & no_gain) | (pend_q & pend_none_q);
    assign spin_o           = spin_q;
    assign energy_o         = pend_q ? pend_energy_q : energy_i;
    assign spin_out_hs      = spin_valid_o & spin_ready_i;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            spin_full_q <= 1'b0;
            pend_q      <= 1'b0;
            pend_none_q <= 1'b0;
        end else if (spin_out_hs) begin
            spin_full_q <= 1'b0;
            pend_q      <= 1'b0;
            pend_none_q <= 1'b0;
        end else begin
            if (spin_in_hs) begin
                spin_full_q <= 1'b1;
            end
            // Downstream stalled, keep the verdict for later
            if (energy_hs) begin
                pend_q      <= 1'b1;
                pend_none_q <= no_gain;
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (spin_in_hs) begin
            spin_q <= spin_i;
        end
        if (energy_hs) begin
            pend_energy_q <= energy_i;
        end
    end

endmodule

`default_nettype wire

// ==== source/energy_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

module energy_fifo (
    input  logic                             clk_i,
    input  logic                             rst_i,
    input  logic                             flush_i,
    input  logic                             push_i,
    input  logic                             pop_i,
    input  logic                             push_none_i,
    input  anneal_pkg::energy_t              data_i,
    output anneal_pkg::energy_t              data_o,
    output logic                             full_o,
    output logic                             empty_o,
    output logic [anneal_pkg::USAGE_BITS-1:0] usage_o
);
    import anneal_pkg::*;

    energy_t               mem_q [FIFO_DEPTH];
    logic [USAGE_BITS-1:0] rd_ptr_q;
    logic [USAGE_BITS-1:0] wr_ptr_q;
    logic [COUNT_BITS-1:0] count_q;
    logic                  do_push;
    logic                  do_pop;
    energy_t               wr_data;

    // Circular pointer step
    function automatic logic [USAGE_BITS-1:0] next_ptr(input logic [USAGE_BITS-1:0] ptr);
        if (ptr == USAGE_BITS'(FIFO_DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign full_o  = (count_q == COUNT_BITS'(FIFO_DEPTH));
    assign empty_o = (count_q == '0);
    assign usage_o = count_q[USAGE_BITS-1:0];
    assign data_o  = mem_q[rd_ptr_q];

    // Push into a full FIFO is fine when the head leaves in the same cycle
    assign do_pop  = pop_i & ~empty_o;
    assign do_push = push_i & (~full_o | do_pop);
    // Push-none recycles the head that is being popped
    assign wr_data = push_none_i ? data_o : data_i;

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            // One entry left behind, slot 0 holds the seed head
            rd_ptr_q <= '0;
            wr_ptr_q <= next_ptr('0);
            count_q  <= COUNT_BITS'(1);
        end else begin
            if (do_push) begin
                wr_ptr_q <= next_ptr(wr_ptr_q);
            end
            if (do_pop) begin
                rd_ptr_q <= next_ptr(rd_ptr_q);
            end
            case ({do_push, do_pop})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i || flush_i) begin
            mem_q[0] <= ENERGY_MAX;
        end else if (do_push) begin
            mem_q[wr_ptr_q] <= wr_data;
        end
    end

endmodule

`default_nettype wire

// ==== source/anneal_pkg.sv ====
`default_nettype none

package anneal_pkg;

    // Ring size and datapath widths
    localparam int NUM_SPINS   = 16;
    localparam int ENERGY_BITS = 12;
    localparam int WEIGHT_BITS = 4;
    localparam int ITER_BITS   = 8;
    localparam int LFSR_BITS   = 16;

    // Energy FIFO geometry, usage is the pointer-wide count as seen on debug
    localparam int FIFO_DEPTH = 2;
    localparam int USAGE_BITS = 1;
    localparam int COUNT_BITS = 2;

    // Wishbone word bus
    localparam int WB_ADDR_BITS = 4;
    localparam int WB_DATA_BITS = 32;

    // Register map word addresses
    localparam logic [WB_ADDR_BITS-1:0] ADDR_CTRL         = 4'd0;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_SEED         = 4'd1;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_H_LO         = 4'd2;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_H_HI         = 4'd3;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_J            = 4'd4;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_INIT_SPIN    = 4'd5;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_BEST_SPIN    = 4'd6;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_BEST_ENERGY  = 4'd7;
    localparam logic [WB_ADDR_BITS-1:0] ADDR_ACCEPT_COUNT = 4'd8;

    // Bit k set means spin k is +1
    typedef logic [NUM_SPINS-1:0] spin_t;
    typedef logic signed [ENERGY_BITS-1:0] energy_t;
    typedef logic signed [WEIGHT_BITS-1:0] weight_t;
    typedef logic [ITER_BITS-1:0] iter_t;
    typedef logic [LFSR_BITS-1:0] lfsr_t;
    typedef logic [WB_DATA_BITS-1:0] wb_data_t;

    // Largest positive energy, also the FIFO head after reset or flush
    localparam energy_t ENERGY_MAX = {1'b0, {(ENERGY_BITS-1){1'b1}}};

    // Run configuration, h[k] is the local field of spin k
    typedef struct packed {
        weight_t [NUM_SPINS-1:0] h;
        weight_t                 j;
        iter_t                   iterations;
        lfsr_t                   seed;
    } anneal_cfg_t;

endpackage

`default_nettype wire
